// File: list.f
+incdir+rtl
+incdir+test
rtl/regs_pkg.sv
rtl/micro_decoder.sv
rtl/bus_mux.sv
rtl/major_register.sv
rtl/reg_ac.sv
rtl/reg_l.sv
rtl/reg_file_top.sv
test/tb_reg_file.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 -f list.f --top-module tb_reg_file -o tb_reg_file; then
   echo "Build failed"
   exit 1
fi

output="$(./obj_dir/tb_reg_file)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST PASSED" <<< "$output"; then
   exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: test/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One table row
//   src, wr {ac,dr,pc}, inc {ac,dr,pc}, ctl {rol,cpl,cll}, ext_data
//   then expected pc, dr, ac and flags {fl,fzero,fneg} once the row has executed
typedef struct packed {
   regs_pkg::bus_src_e src;
   logic [2:0]         wr;
   logic [2:0]         inc;
   logic [2:0]         ctl;
   regs_pkg::word_t    ext_data;
   regs_pkg::word_t    pc;
   regs_pkg::word_t    dr;
   regs_pkg::word_t    ac;
   logic [2:0]         flags;
} vector_t;

localparam int num_vectors = 24;

// Short source names keep each row on one line
localparam regs_pkg::bus_src_e s_none = regs_pkg::src_none;
localparam regs_pkg::bus_src_e s_pc   = regs_pkg::src_pc;
localparam regs_pkg::bus_src_e s_dr   = regs_pkg::src_dr;
localparam regs_pkg::bus_src_e s_ac   = regs_pkg::src_ac;
localparam regs_pkg::bus_src_e s_ext  = regs_pkg::src_ext;

vector_t vectors [num_vectors];
int      vector_fill = 0;

task automatic add_vector(input regs_pkg::bus_src_e src, input logic [2:0] wr,
                          input logic [2:0] inc, input logic [2:0] ctl,
                          input regs_pkg::word_t ext_data, input regs_pkg::word_t e_pc,
                          input regs_pkg::word_t e_dr, input regs_pkg::word_t e_ac,
                          input logic [2:0] flags);
   vectors[vector_fill] = {src, wr, inc, ctl, ext_data, e_pc, e_dr, e_ac, flags};
   vector_fill++;
endtask

task automatic build_table;
   // Bus transfers, every row reads what the row before it wrote
   add_vector(s_ext,  3'h2, 3'h0, 3'h0, 16'h1234, 16'h0000, 16'h1234, 16'h0000, 3'b010);
   add_vector(s_dr,   3'h4, 3'h0, 3'h0, 16'h0000, 16'h0000, 16'h1234, 16'h1234, 3'b000);
   add_vector(s_ac,   3'h1, 3'h0, 3'h0, 16'h0000, 16'h1234, 16'h1234, 16'h1234, 3'b000);
   add_vector(s_none, 3'h0, 3'h7, 3'h0, 16'h0000, 16'h1235, 16'h1235, 16'h1235, 3'b000);
   // Ac wraps to zero and toggles the link, then cpl twice and cll
   add_vector(s_ext,  3'h4, 3'h0, 3'h0, 16'hffff, 16'h1235, 16'h1235, 16'hffff, 3'b001);
   add_vector(s_none, 3'h0, 3'h4, 3'h0, 16'h0000, 16'h1235, 16'h1235, 16'h0000, 3'b110);
   add_vector(s_none, 3'h0, 3'h0, 3'h2, 16'h0000, 16'h1235, 16'h1235, 16'h0000, 3'b010);
   add_vector(s_none, 3'h0, 3'h0, 3'h2, 16'h0000, 16'h1235, 16'h1235, 16'h0000, 3'b110);
   add_vector(s_none, 3'h0, 3'h0, 3'h1, 16'h0000, 16'h1235, 16'h1235, 16'h0000, 3'b010);
   // Rotate left through the link
   add_vector(s_ext,  3'h4, 3'h0, 3'h0, 16'h8001, 16'h1235, 16'h1235, 16'h8001, 3'b001);
   add_vector(s_none, 3'h0, 3'h0, 3'h4, 16'h0000, 16'h1235, 16'h1235, 16'h0002, 3'b100);
   add_vector(s_none, 3'h0, 3'h0, 3'h4, 16'h0000, 16'h1235, 16'h1235, 16'h0005, 3'b000);
   add_vector(s_ext,  3'h4, 3'h0, 3'h0, 16'hc000, 16'h1235, 16'h1235, 16'hc000, 3'b001);
   add_vector(s_none, 3'h0, 3'h0, 3'h4, 16'h0000, 16'h1235, 16'h1235, 16'h8000, 3'b101);
   add_vector(s_none, 3'h0, 3'h0, 3'h4, 16'h0000, 16'h1235, 16'h1235, 16'h0001, 3'b100);
   // Write over inc, write over rotate, rotate over inc
   add_vector(s_ext,  3'h2, 3'h2, 3'h0, 16'h0050, 16'h1235, 16'h0050, 16'h0001, 3'b100);
   add_vector(s_dr,   3'h4, 3'h4, 3'h4, 16'h0000, 16'h1235, 16'h0050, 16'h0050, 3'b100);
   add_vector(s_none, 3'h0, 3'h4, 3'h4, 16'h0000, 16'h1235, 16'h0050, 16'h00a1, 3'b000);
   // Cll beats cpl, and cll beats the carry toggle
   add_vector(s_none, 3'h0, 3'h0, 3'h2, 16'h0000, 16'h1235, 16'h0050, 16'h00a1, 3'b100);
   add_vector(s_none, 3'h0, 3'h0, 3'h3, 16'h0000, 16'h1235, 16'h0050, 16'h00a1, 3'b000);
   add_vector(s_ext,  3'h4, 3'h0, 3'h2, 16'hffff, 16'h1235, 16'h0050, 16'hffff, 3'b101);
   add_vector(s_none, 3'h0, 3'h4, 3'h1, 16'h0000, 16'h1235, 16'h0050, 16'h0000, 3'b010);
   // Old pc onto the bus while pc counts, then the idle bus reads zero
   add_vector(s_pc,   3'h2, 3'h1, 3'h0, 16'h0000, 16'h1236, 16'h1235, 16'h0000, 3'b010);
   add_vector(s_none, 3'h1, 3'h0, 3'h0, 16'h0000, 16'h0000, 16'h1235, 16'h0000, 3'b010);
endtask

`endif

// File: test/tb_reg_file.sv
`default_nettype none
`timescale 1ns/10ps

`include "regs_macros.svh"

module tb_reg_file;

   localparam int clk_period  = 40;
   localparam int drive_delay = 2;
   localparam int random_ops  = 200;

   logic                clock;
   logic                rst_n;
   logic                uop_valid;
   regs_pkg::micro_op_t uop;
   regs_pkg::word_t     pc;
   regs_pkg::word_t     dr;
   regs_pkg::word_t     ac;
   logic                fl;
   logic                fzero;
   logic                fneg;

   // Micro-op and its strobe as one pipeline slot
   typedef struct packed {
      logic                valid;
      regs_pkg::micro_op_t op;
   } pending_t;

   `include "tb_vectors.svh"

   // Slots in flight, oldest first
   pending_t        pending[$];

   // Model state
   regs_pkg::word_t m_pc;
   regs_pkg::word_t m_dr;
   regs_pkg::word_t m_ac;
   logic            m_fl;

   int seed       = 32'h2b67_3deb;
   int pass_count = 0;
   int fail_count = 0;

   reg_file_top reg_file_top_inst (
      .clock     (clock),
      .rst_n     (rst_n),
      .uop_valid (uop_valid),
      .uop       (uop),
      .pc        (pc),
      .dr        (dr),
      .ac        (ac),
      .fl        (fl),
      .fzero     (fzero),
      .fneg      (fneg)
   );

   always #(clk_period / 2) clock = ~clock;

   // Watchdog, table plus random run plus slack
   initial begin
      #((num_vectors + random_ops + 20) * clk_period);
      $display("Timeout: the run did not finish within the expected number of cycles");
      $display("TEST FAILED");
      $finish;
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic drive(input pending_t p);
      uop_valid = p.valid;
      uop       = p.op;
   endtask

   task automatic tally(input logic ok);
      if (ok) begin
         pass_count++;
      end else begin
         fail_count++;
      end
   endtask

   function automatic pending_t vector_uop(input vector_t v);
      pending_t p;
      p             = '0;
      p.valid       = 1'b1;
      p.op.src      = v.src;
      p.op.wr       = v.wr;
      p.op.inc      = v.inc;
      p.op.rol      = v.ctl[2];
      p.op.link     = regs_pkg::link_op_e'(v.ctl[1:0]);
      p.op.ext_data = v.ext_data;
      return p;
   endfunction

   task automatic check_outputs(input string tag, input regs_pkg::word_t e_pc,
                                input regs_pkg::word_t e_dr, input regs_pkg::word_t e_ac,
                                input logic e_fl, input logic e_fz, input logic e_fn,
                                output logic ok);
      ok = 1'b1;
      if (pc !== e_pc) begin
         $display("ERROR %0t pc: %s read %h, expected %h", $time, tag, pc, e_pc);
         ok = 1'b0;
      end
      if (dr !== e_dr) begin
         $display("ERROR %0t dr: %s read %h, expected %h", $time, tag, dr, e_dr);
         ok = 1'b0;
      end
      if (ac !== e_ac) begin
         $display("ERROR %0t ac: %s read %h, expected %h", $time, tag, ac, e_ac);
         ok = 1'b0;
      end
      if (fl !== e_fl) begin
         $display("ERROR %0t fl: %s read %b, expected %b", $time, tag, fl, e_fl);
         ok = 1'b0;
      end
      if (fzero !== e_fz) begin
         $display("ERROR %0t fzero: %s read %b, expected %b", $time, tag, fzero, e_fz);
         ok = 1'b0;
      end
      if (fneg !== e_fn) begin
         $display("ERROR %0t fneg: %s read %b, expected %b", $time, tag, fneg, e_fn);
         ok = 1'b0;
      end
   endtask

   // Model of one execute step, bus taken from the values before it
   task automatic apply_model(input pending_t p);
      regs_pkg::word_t bus;
      regs_pkg::word_t old_ac;
      logic            old_fl;
      logic            rotated;
      logic            carry;
      old_ac  = m_ac;
      old_fl  = m_fl;
      rotated = 1'b0;
      carry   = 1'b0;
      if (p.valid) begin
         case (p.op.src)
            regs_pkg::src_pc:  bus = m_pc;
            regs_pkg::src_dr:  bus = m_dr;
            regs_pkg::src_ac:  bus = m_ac;
            regs_pkg::src_ext: bus = p.op.ext_data;
            default:           bus = '0;
         endcase
         if (p.op.wr[`MASK_PC]) begin
            m_pc = bus;
         end else if (p.op.inc[`MASK_PC]) begin
            m_pc = m_pc + 16'd1;
         end
         if (p.op.wr[`MASK_DR]) begin
            m_dr = bus;
         end else if (p.op.inc[`MASK_DR]) begin
            m_dr = m_dr + 16'd1;
         end
         // Ac order is write, rotate, count
         if (p.op.wr[`MASK_AC]) begin
            m_ac = bus;
         end else if (p.op.rol) begin
            m_ac    = {old_ac[`REG_WIDTH-2:0], old_fl};
            rotated = 1'b1;
         end else if (p.op.inc[`MASK_AC]) begin
            carry = (old_ac == 16'hffff);
            m_ac  = old_ac + 16'd1;
         end
         // Link order is clear, rotate load, toggle
         if (p.op.link[0]) begin
            m_fl = 1'b0;
         end else if (rotated) begin
            m_fl = old_ac[`REG_WIDTH-1];
         end else if (p.op.link[1] || carry) begin
            m_fl = ~old_fl;
         end
      end
   endtask

   task automatic random_uop(output pending_t p);
      int unsigned r;
      int unsigned sel;
      p         = '0;
      r         = $random(seed);
      p.op.wr   = r[2:0];
      p.op.inc  = r[5:3];
      // Rotate about one slot in four
      p.op.rol  = r[6] & r[9];
      p.op.link = regs_pkg::link_op_e'(r[8:7]);
      p.op.spare = r[31:16];
      // Idle about one slot in eight, fields left as junk
      p.valid   = (r[12:10] != 3'd0);
      r         = $random(seed);
      sel       = r % 32'd5;
      p.op.src  = regs_pkg::bus_src_e'(sel[2:0]);
      r         = $random(seed);
      // All ones half the time so the ac wrap shows up
      if (r[0]) begin
         p.op.ext_data = 16'hffff;
      end else begin
         p.op.ext_data = r[31:16];
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      pending_t p;
      vector_t  v;
      logic     ok;
      int       k;
      int       random_errors;
      clock     = 1'b0;
      rst_n     = 1'b0;
      uop_valid = 1'b0;
      uop       = '0;
      build_table();
      repeat (4) @(posedge clock);
      #drive_delay;
      rst_n = 1'b1;

      check_outputs("reset", 16'h0000, 16'h0000, 16'h0000, 1'b0, 1'b1, 1'b0, ok);
      tally(ok);
      $display("reset: %s", ok ? "ok" : "mismatch");

      // Table back to back, row k shows up UOP_LATENCY edges after it is driven
      for (int i = 0; i < num_vectors + `UOP_LATENCY; i++) begin
         if (i >= `UOP_LATENCY) begin
            k = i - `UOP_LATENCY;
            v = vectors[k];
            check_outputs($sformatf("vector %0d", k), v.pc, v.dr, v.ac,
                          v.flags[2], v.flags[1], v.flags[0], ok);
            tally(ok);
            $display("vector %0d: %s", k, ok ? "ok" : "mismatch");
         end
         if (i < num_vectors) begin
            drive(vector_uop(vectors[i]));
         end else begin
            drive('0);
         end
         @(posedge clock);
         #drive_delay;
      end

      // Model picks up where the table left off
      v             = vectors[num_vectors-1];
      m_pc          = v.pc;
      m_dr          = v.dr;
      m_ac          = v.ac;
      m_fl          = v.flags[2];
      random_errors = 0;
      repeat (`UOP_LATENCY) pending.push_back('0);

      for (int j = 0; j < random_ops + `UOP_LATENCY; j++) begin
         apply_model(pending.pop_front());
         check_outputs($sformatf("random cycle %0d", j), m_pc, m_dr, m_ac, m_fl,
                       m_ac == '0, m_ac[`REG_WIDTH-1], ok);
         tally(ok);
         if (!ok) begin
            random_errors++;
         end
         if (j < random_ops) begin
            random_uop(p);
         end else begin
            p = '0;
         end
         drive(p);
         pending.push_back(p);
         @(posedge clock);
         #drive_delay;
      end
      $display("random phase: %0d cycles, %0d mismatching", random_ops + `UOP_LATENCY,
               random_errors);

      $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/reg_file_top.sv
`default_nettype none
`timescale 1ns/10ps

module reg_file_top (
   input  logic                clock,
   input  logic                rst_n,
   input  logic                uop_valid,
   input  regs_pkg::micro_op_t uop,
   output regs_pkg::word_t     pc,
   output regs_pkg::word_t     dr,
   output regs_pkg::word_t     ac,
   output logic                fl,
   output logic                fzero,
   output logic                fneg
);

   // Two stages, `UOP_LATENCY edges from strobe to outputs
   //   edge N    decode registers the strobes
   //   edge N+1  registers and link update
   regs_pkg::reg_strobe_t strobe;
   regs_pkg::word_t       ibus;
   logic                  ac_carry;
   logic                  ac_msb;

   ////////////////////
   // Decode
   ////////////////////

   micro_decoder micro_decoder_inst (
      .clock     (clock),
      .rst_n     (rst_n),
      .uop_valid (uop_valid),
      .uop       (uop),
      .strobe    (strobe)
   );

   ////////////////////
   // Execute
   ////////////////////

   bus_mux bus_mux_inst (
      .strobe (strobe),
      .pc     (pc),
      .dr     (dr),
      .ac     (ac),
      .ibus   (ibus)
   );

   // Program counter
   major_register pc_reg_inst (
      .clock (clock),
      .rst_n (rst_n),
      .load  (strobe.pc_load),
      .inc   (strobe.pc_inc),
      .din   (ibus),
      .q     (pc),
      .carry ()
   );

   // Data register
   major_register dr_reg_inst (
      .clock (clock),
      .rst_n (rst_n),
      .load  (strobe.dr_load),
      .inc   (strobe.dr_inc),
      .din   (ibus),
      .q     (dr),
      .carry ()
   );

   // Accumulator, link feeds the rotate
   reg_ac reg_ac_inst (
      .clock    (clock),
      .rst_n    (rst_n),
      .strobe   (strobe),
      .ibus     (ibus),
      .fl       (fl),
      .ac       (ac),
      .ac_carry (ac_carry),
      .ac_msb   (ac_msb),
      .fzero    (fzero),
      .fneg     (fneg)
   );

   reg_l reg_l_inst (
      .clock    (clock),
      .rst_n    (rst_n),
      .strobe   (strobe),
      .ac_carry (ac_carry),
      .ac_msb   (ac_msb),
      .fl       (fl)
   );

endmodule

`default_nettype wire

// File: rtl/reg_l.sv
`default_nettype none
`timescale 1ns/10ps

module reg_l (
   input  logic                  clock,
   input  logic                  rst_n,
   input  regs_pkg::reg_strobe_t strobe,
   input  logic                  ac_carry,
   input  logic                  ac_msb,
   output logic                  fl
);

   // Toggle from cpl or from the ac increment carry
   logic toggle;

   assign toggle = strobe.l_toggle_cpl | ac_carry;

   ////////////////////
   // Link flip-flop
   ////////////////////

   // JK behavior folded into one priority chain
   //   clear     -> J=0 K=1
   //   rotate    -> J=msb K=~msb
   //   toggle    -> J=1 K=1
   //   otherwise hold
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         fl <= 1'b0;
      end else if (strobe.l_clear) begin
         // cll overrides rotate and any carry toggle
         fl <= 1'b0;
      end else if (strobe.ac_rol) begin
         // Bit 15 of the old ac shifts out into the link
         fl <= ac_msb;
      end else if (toggle) begin
         fl <= ~fl;
      end
   end

endmodule

`default_nettype wire

// File: rtl/reg_ac.sv
`default_nettype none
`timescale 1ns/10ps

module reg_ac (
   input  logic                  clock,
   input  logic                  rst_n,
   input  regs_pkg::reg_strobe_t strobe,
   input  regs_pkg::word_t       ibus,
   input  logic                  fl,
   output regs_pkg::word_t       ac,
   output logic                  ac_carry,
   output logic                  ac_msb,
   output logic                  fzero,
   output logic                  fneg
);

   // Load path shared by bus write and rotate
   logic            ac_load;
   regs_pkg::word_t ac_din;
   regs_pkg::word_t ac_rotated;

   // Rotate left through the link
   assign ac_rotated = {ac[$bits(regs_pkg::word_t)-2:0], fl};

   // Decoder keeps load and rotate apart, rotate picks the mux
   assign ac_load = strobe.ac_load | strobe.ac_rol;
   assign ac_din  = strobe.ac_rol ? ac_rotated : ibus;

   major_register #(
      .WIDTH ($bits(regs_pkg::word_t))
   ) ac_reg_inst (
      .clock (clock),
      .rst_n (rst_n),
      .load  (ac_load),
      .inc   (strobe.ac_inc),
      .din   (ac_din),
      .q     (ac),
      .carry ()
   );

   ////////////////////
   // Flags
   ////////////////////

   // Wrap seen before the edge so the link toggles together with ac
   assign ac_carry = strobe.ac_inc & (&ac);

   // Old msb goes to the link on rotate
   assign ac_msb = ac[$bits(regs_pkg::word_t)-1];

   // Zero compare replaces the comparator pair
   assign fzero = (ac == '0);
   assign fneg  = ac[$bits(regs_pkg::word_t)-1];

endmodule

`default_nettype wire

// File: rtl/major_register.sv
`default_nettype none
`timescale 1ns/10ps

`include "regs_macros.svh"

module major_register #(
   parameter int WIDTH = `REG_WIDTH
) (
   input  logic             clock,
   input  logic             rst_n,
   input  logic             load,
   input  logic             inc,
   input  logic [WIDTH-1:0] din,
   output logic [WIDTH-1:0] q,
   output logic             carry
);

   // Increment about to roll over from all ones
   logic wrap;

   assign wrap = inc & ~load & (&q);

   ////////////////////
   // Counter
   ////////////////////

   // Load has priority over count
   // A single adder replaces the counter chain
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         q <= '0;
      end else if (load) begin
         q <= din;
      end else if (inc) begin
         q <= q + 1'b1;
      end
   end

   // Carry out, one cycle pulse after the wrap
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         carry <= 1'b0;
      end else begin
         carry <= wrap;
      end
   end

endmodule

`default_nettype wire

// File: rtl/bus_mux.sv
`default_nettype none
`timescale 1ns/10ps

module bus_mux (
   input  regs_pkg::reg_strobe_t strobe,
   input  regs_pkg::word_t       pc,
   input  regs_pkg::word_t       dr,
   input  regs_pkg::word_t       ac,
   output regs_pkg::word_t       ibus
);

   // Internal bus as a plain multiplexer
   // Sources are the register values before the next edge, so a
   // micro-op right behind another one reads its results
   always_comb begin
      unique case (strobe.src)
         regs_pkg::src_pc: begin
            ibus = pc;
         end
         regs_pkg::src_dr: begin
            ibus = dr;
         end
         regs_pkg::src_ac: begin
            ibus = ac;
         end
         regs_pkg::src_ext: begin
            // Data latched with the micro-op
            ibus = strobe.ext_data;
         end
         default: begin
            // Idle bus reads as zero, like the pull-downs
            ibus = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/micro_decoder.sv
`default_nettype none
`timescale 1ns/10ps

`include "regs_macros.svh"

module micro_decoder (
   input  logic                  clock,
   input  logic                  rst_n,
   input  logic                  uop_valid,
   input  regs_pkg::micro_op_t   uop,
   output regs_pkg::reg_strobe_t strobe
);

   regs_pkg::reg_strobe_t strobe_d;

   // Qualified register requests
   logic wr_pc;
   logic wr_dr;
   logic wr_ac;
   logic inc_pc;
   logic inc_dr;
   logic inc_ac;
   logic rol_ac;

   // Link requests, one bit each
   logic cll_req;
   logic cpl_req;

   ////////////////////
   // Expansion
   ////////////////////

   always_comb begin
      // Everything is gated with the strobe
      wr_pc   = uop_valid & uop.wr[`MASK_PC];
      wr_dr   = uop_valid & uop.wr[`MASK_DR];
      wr_ac   = uop_valid & uop.wr[`MASK_AC];
      inc_pc  = uop_valid & uop.inc[`MASK_PC];
      inc_dr  = uop_valid & uop.inc[`MASK_DR];
      inc_ac  = uop_valid & uop.inc[`MASK_AC];
      rol_ac  = uop_valid & uop.rol;
      cll_req = uop_valid & uop.link[0];
      cpl_req = uop_valid & uop.link[1];

      strobe_d.src = uop_valid ? uop.src : regs_pkg::src_none;

      // Write beats increment
      strobe_d.pc_load = wr_pc;
      strobe_d.pc_inc  = inc_pc & ~wr_pc;
      strobe_d.dr_load = wr_dr;
      strobe_d.dr_inc  = inc_dr & ~wr_dr;

      // On ac the order is write, then rotate, then increment
      strobe_d.ac_load = wr_ac;
      strobe_d.ac_rol  = rol_ac & ~wr_ac;
      strobe_d.ac_inc  = inc_ac & ~wr_ac & ~rol_ac;

      // Clear wins over complement on the link
      strobe_d.l_clear      = cll_req;
      strobe_d.l_toggle_cpl = cpl_req & ~cll_req;

      strobe_d.ext_data = uop_valid ? uop.ext_data : '0;
   end

   ////////////////////
   // Decode register
   ////////////////////

   // One cycle, all strobes idle out of reset
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         strobe <= '0;
      end else begin
         strobe <= strobe_d;
      end
   end

endmodule

`default_nettype wire

// File: rtl/regs_pkg.sv
`default_nettype none

`include "regs_macros.svh"

package regs_pkg;

   // Register and bus value
   typedef logic [`REG_WIDTH-1:0] word_t;

   // One bit per major register, see MASK_* positions
   typedef logic [`MASK_WIDTH-1:0] reg_mask_t;

   // Internal bus source
   typedef enum logic [2:0] {
      src_none = 3'd0,
      src_pc   = 3'd1,
      src_dr   = 3'd2,
      src_ac   = 3'd3,
      src_ext  = 3'd4
   } bus_src_e;

   // Link operation, one-hot so 2'b11 asks for cll and cpl together
   typedef enum logic [1:0] {
      link_none = 2'b00,
      link_cll  = 2'b01,
      link_cpl  = 2'b10
   } link_op_e;

   // Micro-op word as driven from outside, 44 bits
   typedef struct packed {
      logic [15:0] spare;
      bus_src_e    src;
      reg_mask_t   wr;
      reg_mask_t   inc;
      logic        rol;
      link_op_e    link;
      word_t       ext_data;
   } micro_op_t;

   // Registered per-register strobes out of the decode stage
   typedef struct packed {
      bus_src_e src;
      logic     pc_load;
      logic     pc_inc;
      logic     dr_load;
      logic     dr_inc;
      logic     ac_load;
      logic     ac_inc;
      logic     ac_rol;
      logic     l_clear;
      logic     l_toggle_cpl;
      word_t    ext_data;
   } reg_strobe_t;

endpackage

`default_nettype wire

// File: rtl/regs_macros.svh
`ifndef REGS_MACROS_SVH
`define REGS_MACROS_SVH

// Width of pc, dr, ac and the internal bus
`define REG_WIDTH 16

// Clock edges from micro-op strobe to visible result
// Edge N samples the micro-op, edge N+1 updates the registers
`define UOP_LATENCY 2

// Bit positions inside a register mask
`define MASK_PC 0
`define MASK_DR 1
`define MASK_AC 2

// Number of registers covered by a mask
`define MASK_WIDTH 3

`endif
